// ==== fir_parallel.f ====
rtl/fir_par_pkg.sv
rtl/reg_bus_if.sv
rtl/reg_bus_demux.sv
rtl/fir_segment.sv
rtl/fir_adder_tree.sv
rtl/fir_ctrl.sv
rtl/fir_parallel.sv
tb/tb_clk_gen.sv
tb/fir_parallel_assert.sv
tb/fir_parallel_tb.sv

// ==== rtl/fir_adder_tree.sv ====
`timescale 1ns/1ps

module fir_adder_tree (
	input  logic clk_i,
	input  logic rst_ni,
	input  logic signed [fir_par_pkg::SEG_SUM_W-1:0] sums_i [fir_par_pkg::NUM_SEG],
	input  logic valid_i,
	output logic signed [fir_par_pkg::Y_W-1:0] y_o,
	output logic y_valid_o
);

	// heap order, node n adds children 2n+1 and 2n+2, root at 0
	logic signed [fir_par_pkg::Y_W-1:0] node_q [fir_par_pkg::NUM_SEG-1];
	logic [fir_par_pkg::TREE_STAGES-1:0] vld_q;

	for (genvar n = 0; n < fir_par_pkg::NUM_SEG - 1; n++) begin : g_node
		logic signed [fir_par_pkg::Y_W-1:0] a;
		logic signed [fir_par_pkg::Y_W-1:0] b;

		// power of two count, so both children sit on the same level
		if (2 * n + 1 >= fir_par_pkg::NUM_SEG - 1) begin : g_leaf
			assign a = {{fir_par_pkg::TREE_STAGES{sums_i[2*n+2-fir_par_pkg::NUM_SEG]
				[fir_par_pkg::SEG_SUM_W-1]}}, sums_i[2*n+2-fir_par_pkg::NUM_SEG]};
			assign b = {{fir_par_pkg::TREE_STAGES{sums_i[2*n+3-fir_par_pkg::NUM_SEG]
				[fir_par_pkg::SEG_SUM_W-1]}}, sums_i[2*n+3-fir_par_pkg::NUM_SEG]};
		end else begin : g_inner
			assign a = node_q[2*n+1];
			assign b = node_q[2*n+2];
		end

		always_ff @(posedge clk_i) begin
			node_q[n] <= a + b;
		end
	end

	// valid walks alongside, one bit per level
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			vld_q <= '0;
		end else begin
			vld_q <= vld_q << 1;
			vld_q[0] <= valid_i;
		end
	end

	assign y_o = node_q[0];
	assign y_valid_o = vld_q[fir_par_pkg::TREE_STAGES-1];

endmodule

// ==== rtl/fir_ctrl.sv ====
`timescale 1ns/1ps

module fir_ctrl (
	input  logic clk_i,
	input  logic rst_ni,
	reg_bus_if.device bus,
	input  logic sample_valid_i,
	input  logic signed [fir_par_pkg::SAMPLE_W-1:0] sample_i,
	output logic strobe_o,
	output logic signed [fir_par_pkg::SAMPLE_W-1:0] sample_o,
	input  logic signed [fir_par_pkg::SAMPLE_W-1:0] shift_last_i,
	input  logic signed [fir_par_pkg::Y_W-1:0] y_i,
	input  logic y_valid_i
);

	logic sv_q;
	logic sv_qq;
	logic edge_det;
	logic armed_q;
	logic signed [fir_par_pkg::SAMPLE_W-1:0] sample_q;
	logic signed [fir_par_pkg::SAMPLE_W-1:0] inject_q;
	logic signed [fir_par_pkg::SAMPLE_W-1:0] shift_q;
	logic signed [fir_par_pkg::Y_W-1:0] y_q;
	logic signed [fir_par_pkg::Y_W-1:0] y_hi;
	logic [fir_par_pkg::OFS_W-1:0] ofs;
	logic [fir_par_pkg::DATA_W-1:0] rd_data;
	logic [fir_par_pkg::DATA_W-1:0] rsp_rdata_q;
	logic rsp_valid_q;
	logic req_fire;
	logic inject_wr;

	// held strobe counts once
	assign edge_det = sv_q & ~sv_qq;

	assign ofs = bus.req_addr[fir_par_pkg::OFS_W-1:0];
	assign req_fire = bus.req_valid & bus.req_ready;
	assign inject_wr = req_fire & bus.req_write & (ofs == fir_par_pkg::OFS_INJECT);

	// sample as seen at the sampling edge
	always_ff @(posedge clk_i) begin
		sample_q <= sample_i;
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			sv_q <= 1'b0;
			sv_qq <= 1'b0;
			strobe_o <= 1'b0;
			sample_o <= '0;
			armed_q <= 1'b0;
			inject_q <= '0;
		end else begin
			sv_q <= sample_valid_i;
			sv_qq <= sv_q;
			strobe_o <= edge_det;
			if (edge_det) begin
				sample_o <= armed_q ? inject_q : sample_q;
				armed_q <= 1'b0;
			end
			// a new write re-arms even when the old value goes out now
			if (inject_wr) begin
				inject_q <= bus.req_wdata[fir_par_pkg::SAMPLE_W-1:0];
				armed_q <= 1'b1;
			end
		end
	end

	// readback of last output and of the sample leaving the line
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			y_q <= '0;
			shift_q <= '0;
		end else begin
			if (y_valid_i) begin
				y_q <= y_i;
			end
			if (strobe_o) begin
				shift_q <= shift_last_i;
			end
		end
	end

	assign y_hi = y_q >>> fir_par_pkg::DATA_W;

	always_comb begin
		case (ofs)
			fir_par_pkg::OFS_Y_LO: rd_data = y_q[fir_par_pkg::DATA_W-1:0];
			fir_par_pkg::OFS_Y_HI: rd_data = y_hi[fir_par_pkg::DATA_W-1:0];
			fir_par_pkg::OFS_SHIFT_OUT: rd_data = {{(fir_par_pkg::DATA_W - fir_par_pkg::SAMPLE_W)
				{shift_q[fir_par_pkg::SAMPLE_W-1]}}, shift_q};
			// inject is write-only
			default: rd_data = '0;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			rsp_valid_q <= 1'b0;
			rsp_rdata_q <= '0;
		end else if (req_fire) begin
			rsp_valid_q <= 1'b1;
			rsp_rdata_q <= bus.req_write ? '0 : rd_data;
		end else if (bus.rsp_ready) begin
			rsp_valid_q <= 1'b0;
		end
	end

	assign bus.req_ready = ~rsp_valid_q;
	assign bus.rsp_valid = rsp_valid_q;
	assign bus.rsp_rdata = rsp_rdata_q;
	assign bus.rsp_error = 1'b0;

endmodule

// ==== rtl/fir_par_pkg.sv ====
package fir_par_pkg;

	// sample and coefficient width
	localparam int unsigned SAMPLE_W = 16;

	// segment count, power of two only
	localparam int unsigned NUM_SEG = 2;
	localparam int unsigned TAPS_PER_SEG = 4;

	// 32-bit product plus two bits of growth over four taps
	localparam int unsigned SEG_SUM_W = 2 * SAMPLE_W + $clog2(TAPS_PER_SEG);

	// one register level per halving of the segment count
	localparam int unsigned TREE_STAGES = $clog2(NUM_SEG);
	localparam int unsigned Y_W = SEG_SUM_W + TREE_STAGES;

	// register bus, word addresses
	localparam int unsigned REGION_W = 2;
	localparam int unsigned OFS_W = 4;
	localparam int unsigned ADDR_W = REGION_W + OFS_W;
	localparam int unsigned DATA_W = 32;

	// segment s decodes as region s, control block follows them
	localparam int unsigned REGION_CTRL = NUM_SEG;

	// control block offsets
	localparam int unsigned OFS_INJECT = 0;
	localparam int unsigned OFS_Y_LO = 1;
	localparam int unsigned OFS_Y_HI = 2;
	localparam int unsigned OFS_SHIFT_OUT = 3;

endpackage

// ==== rtl/fir_parallel.sv ====
`timescale 1ns/1ps

module fir_parallel (
	input  logic clk_i,
	input  logic rst_ni,
	input  logic sample_valid_i,
	input  logic signed [fir_par_pkg::SAMPLE_W-1:0] sample_i,
	output logic y_valid_o,
	output logic signed [fir_par_pkg::Y_W-1:0] y_o,
	input  logic req_valid_i,
	output logic req_ready_o,
	input  logic req_write_i,
	input  logic [fir_par_pkg::ADDR_W-1:0] req_addr_i,
	input  logic [fir_par_pkg::DATA_W-1:0] req_wdata_i,
	output logic rsp_valid_o,
	input  logic rsp_ready_i,
	output logic [fir_par_pkg::DATA_W-1:0] rsp_rdata_o,
	output logic rsp_error_o
);

	reg_bus_if host_bus ();
	reg_bus_if ctrl_bus ();
	reg_bus_if seg_bus [fir_par_pkg::NUM_SEG] ();

	logic strobe;
	logic signed [fir_par_pkg::SAMPLE_W-1:0] first_sample;
	logic signed [fir_par_pkg::SAMPLE_W-1:0] seg_in [fir_par_pkg::NUM_SEG];
	logic signed [fir_par_pkg::SAMPLE_W-1:0] seg_shift [fir_par_pkg::NUM_SEG];
	logic signed [fir_par_pkg::SEG_SUM_W-1:0] seg_sum [fir_par_pkg::NUM_SEG];
	logic [fir_par_pkg::NUM_SEG-1:0] seg_valid;

	assign host_bus.req_valid = req_valid_i;
	assign host_bus.req_write = req_write_i;
	assign host_bus.req_addr = req_addr_i;
	assign host_bus.req_wdata = req_wdata_i;
	assign host_bus.rsp_ready = rsp_ready_i;
	assign req_ready_o = host_bus.req_ready;
	assign rsp_valid_o = host_bus.rsp_valid;
	assign rsp_rdata_o = host_bus.rsp_rdata;
	assign rsp_error_o = host_bus.rsp_error;

	reg_bus_demux u_demux (
		.clk_i  (clk_i),
		.rst_ni (rst_ni),
		.host   (host_bus.device),
		.dev0_o (seg_bus[0].host),
		.dev1_o (seg_bus[1].host),
		.ctrl_o (ctrl_bus.host)
	);

	fir_ctrl u_ctrl (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.bus            (ctrl_bus.device),
		.sample_valid_i (sample_valid_i),
		.sample_i       (sample_i),
		.strobe_o       (strobe),
		.sample_o       (first_sample),
		.shift_last_i   (seg_shift[fir_par_pkg::NUM_SEG-1]),
		.y_i            (y_o),
		.y_valid_i      (y_valid_o)
	);

	// segments chained into one delay line
	for (genvar s = 0; s < fir_par_pkg::NUM_SEG; s++) begin : g_seg
		if (s == 0) begin : g_first
			assign seg_in[s] = first_sample;
		end else begin : g_next
			assign seg_in[s] = seg_shift[s-1];
		end

		fir_segment u_seg (
			.clk_i       (clk_i),
			.rst_ni      (rst_ni),
			.bus         (seg_bus[s].device),
			.strobe_i    (strobe),
			.sample_i    (seg_in[s]),
			.shift_o     (seg_shift[s]),
			.sum_o       (seg_sum[s]),
			.sum_valid_o (seg_valid[s])
		);
	end

	fir_adder_tree u_tree (
		.clk_i     (clk_i),
		.rst_ni    (rst_ni),
		.sums_i    (seg_sum),
		.valid_i   (&seg_valid),
		.y_o       (y_o),
		.y_valid_o (y_valid_o)
	);

endmodule

// ==== rtl/fir_segment.sv ====
`timescale 1ns/1ps

module fir_segment (
	input  logic clk_i,
	input  logic rst_ni,
	reg_bus_if.device bus,
	input  logic strobe_i,
	input  logic signed [fir_par_pkg::SAMPLE_W-1:0] sample_i,
	output logic signed [fir_par_pkg::SAMPLE_W-1:0] shift_o,
	output logic signed [fir_par_pkg::SEG_SUM_W-1:0] sum_o,
	output logic sum_valid_o
);

	logic signed [fir_par_pkg::SAMPLE_W-1:0] coef_q [fir_par_pkg::TAPS_PER_SEG];
	logic signed [fir_par_pkg::SAMPLE_W-1:0] line_q [fir_par_pkg::TAPS_PER_SEG];
	logic signed [fir_par_pkg::SAMPLE_W-1:0] line_d [fir_par_pkg::TAPS_PER_SEG];
	logic signed [fir_par_pkg::SEG_SUM_W-1:0] sum_d;
	logic [fir_par_pkg::OFS_W-1:0] ofs;
	logic [fir_par_pkg::DATA_W-1:0] rd_data;
	logic [fir_par_pkg::DATA_W-1:0] rsp_rdata_q;
	logic rsp_valid_q;
	logic req_fire;

	// line contents after this strobe, newest at index 0
	always_comb begin
		line_d[0] = sample_i;
		for (int k = 1; k < fir_par_pkg::TAPS_PER_SEG; k++) begin
			line_d[k] = line_q[k-1];
		end
	end

	always_comb begin
		logic signed [2*fir_par_pkg::SAMPLE_W-1:0] prod;
		sum_d = '0;
		for (int k = 0; k < fir_par_pkg::TAPS_PER_SEG; k++) begin
			prod = line_d[k] * coef_q[k];
			sum_d = sum_d + {{(fir_par_pkg::SEG_SUM_W - 2 * fir_par_pkg::SAMPLE_W)
				{prod[2*fir_par_pkg::SAMPLE_W-1]}}, prod};
		end
	end

	// oldest stage continues into the next segment
	assign shift_o = line_q[fir_par_pkg::TAPS_PER_SEG-1];

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			line_q <= '{default: '0};
			sum_valid_o <= 1'b0;
		end else begin
			sum_valid_o <= strobe_i;
			if (strobe_i) begin
				line_q <= line_d;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (strobe_i) begin
			sum_o <= sum_d;
		end
	end

	// coefficient registers on the bus
	assign ofs = bus.req_addr[fir_par_pkg::OFS_W-1:0];
	assign req_fire = bus.req_valid & bus.req_ready;

	always_comb begin
		rd_data = '0;
		for (int k = 0; k < fir_par_pkg::TAPS_PER_SEG; k++) begin
			if (ofs == k) begin
				rd_data = {{(fir_par_pkg::DATA_W - fir_par_pkg::SAMPLE_W)
					{coef_q[k][fir_par_pkg::SAMPLE_W-1]}}, coef_q[k]};
			end
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			coef_q <= '{default: '0};
		end else if (req_fire && bus.req_write) begin
			for (int k = 0; k < fir_par_pkg::TAPS_PER_SEG; k++) begin
				if (ofs == k) begin
					coef_q[k] <= bus.req_wdata[fir_par_pkg::SAMPLE_W-1:0];
				end
			end
		end
	end

	// response one cycle after acceptance, held until taken
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			rsp_valid_q <= 1'b0;
			rsp_rdata_q <= '0;
		end else if (req_fire) begin
			rsp_valid_q <= 1'b1;
			rsp_rdata_q <= bus.req_write ? '0 : rd_data;
		end else if (bus.rsp_ready) begin
			rsp_valid_q <= 1'b0;
		end
	end

	assign bus.req_ready = ~rsp_valid_q;
	assign bus.rsp_valid = rsp_valid_q;
	assign bus.rsp_rdata = rsp_rdata_q;
	assign bus.rsp_error = 1'b0;

endmodule

// ==== rtl/reg_bus_demux.sv ====
`timescale 1ns/1ps

module reg_bus_demux (
	input logic clk_i,
	input logic rst_ni,
	reg_bus_if.device host,
	reg_bus_if.host dev0_o,
	reg_bus_if.host dev1_o,
	reg_bus_if.host ctrl_o
);

	logic [fir_par_pkg::REGION_W-1:0] region;
	logic [fir_par_pkg::REGION_W-1:0] owner_q;
	logic bus_en_q;
	logic busy_q;
	logic sel_ready;
	logic can_accept;

	assign region = host.req_addr[fir_par_pkg::ADDR_W-1 -: fir_par_pkg::REGION_W];

	// closed while in reset and while a response is still pending
	assign can_accept = bus_en_q & ~busy_q;

	always_comb begin
		case (region)
			0: sel_ready = dev0_o.req_ready;
			1: sel_ready = dev1_o.req_ready;
			fir_par_pkg::REGION_CTRL: sel_ready = ctrl_o.req_ready;
			// unmapped region, answered here
			default: sel_ready = 1'b1;
		endcase
	end

	assign host.req_ready = can_accept & sel_ready;

	assign dev0_o.req_valid = host.req_valid & can_accept & (region == 0);
	assign dev1_o.req_valid = host.req_valid & can_accept & (region == 1);
	assign ctrl_o.req_valid = host.req_valid & can_accept & (region == fir_par_pkg::REGION_CTRL);

	assign dev0_o.req_write = host.req_write;
	assign dev1_o.req_write = host.req_write;
	assign ctrl_o.req_write = host.req_write;
	assign dev0_o.req_addr = host.req_addr;
	assign dev1_o.req_addr = host.req_addr;
	assign ctrl_o.req_addr = host.req_addr;
	assign dev0_o.req_wdata = host.req_wdata;
	assign dev1_o.req_wdata = host.req_wdata;
	assign ctrl_o.req_wdata = host.req_wdata;

	// only the owner of the outstanding request sees rsp_ready
	assign dev0_o.rsp_ready = host.rsp_ready & busy_q & (owner_q == 0);
	assign dev1_o.rsp_ready = host.rsp_ready & busy_q & (owner_q == 1);
	assign ctrl_o.rsp_ready = host.rsp_ready & busy_q & (owner_q == fir_par_pkg::REGION_CTRL);

	always_comb begin
		host.rsp_valid = busy_q;
		host.rsp_rdata = '0;
		host.rsp_error = 1'b1;
		case (owner_q)
			0: begin
				host.rsp_valid = busy_q & dev0_o.rsp_valid;
				host.rsp_rdata = dev0_o.rsp_rdata;
				host.rsp_error = dev0_o.rsp_error;
			end
			1: begin
				host.rsp_valid = busy_q & dev1_o.rsp_valid;
				host.rsp_rdata = dev1_o.rsp_rdata;
				host.rsp_error = dev1_o.rsp_error;
			end
			fir_par_pkg::REGION_CTRL: begin
				host.rsp_valid = busy_q & ctrl_o.rsp_valid;
				host.rsp_rdata = ctrl_o.rsp_rdata;
				host.rsp_error = ctrl_o.rsp_error;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			bus_en_q <= 1'b0;
			busy_q <= 1'b0;
			owner_q <= '0;
		end else begin
			bus_en_q <= 1'b1;
			if (host.req_valid && host.req_ready) begin
				busy_q <= 1'b1;
				owner_q <= region;
			end else if (host.rsp_valid && host.rsp_ready) begin
				busy_q <= 1'b0;
			end
		end
	end

endmodule

// ==== rtl/reg_bus_if.sv ====
`timescale 1ns/1ps

interface reg_bus_if;

	// request channel
	logic req_valid;
	logic req_ready;
	logic req_write;
	logic [fir_par_pkg::ADDR_W-1:0] req_addr;
	logic [fir_par_pkg::DATA_W-1:0] req_wdata;

	// response channel
	logic rsp_valid;
	logic rsp_ready;
	logic [fir_par_pkg::DATA_W-1:0] rsp_rdata;
	logic rsp_error;

	modport host (
		output req_valid, req_write, req_addr, req_wdata, rsp_ready,
		input  req_ready, rsp_valid, rsp_rdata, rsp_error
	);

	modport device (
		input  req_valid, req_write, req_addr, req_wdata, rsp_ready,
		output req_ready, rsp_valid, rsp_rdata, rsp_error
	);

endinterface

// ==== tb/fir_parallel_assert.sv ====
`timescale 1ns/1ps

module fir_parallel_assert (
	input logic clk_i,
	input logic rst_ni,
	input logic req_valid_i,
	input logic req_ready_i,
	input logic req_write_i,
	input logic [fir_par_pkg::ADDR_W-1:0] req_addr_i,
	input logic [fir_par_pkg::DATA_W-1:0] req_wdata_i,
	input logic rsp_valid_i,
	input logic rsp_ready_i,
	input logic [fir_par_pkg::DATA_W-1:0] rsp_rdata_i,
	input logic rsp_error_i,
	input logic y_valid_i
);

	// a waiting request keeps its payload
	req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_write_i)
			&& $stable(req_addr_i) && $stable(req_wdata_i))
		else $error("request payload changed before it was accepted");

	// stalled response stays put
	rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_rdata_i)
			&& $stable(rsp_error_i))
		else $error("response changed while rsp_ready was low");

	y_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
		y_valid_i |=> !y_valid_i)
		else $error("y_valid_o high for two cycles in a row");

endmodule

// ==== tb/fir_parallel_tb.sv ====
`timescale 1ns/1ps

module fir_parallel_tb;

	// roughly ten times the summed length of all tests
	localparam int unsigned TIMEOUT_CYC = 4000;
	localparam int unsigned NTAPS = fir_par_pkg::NUM_SEG * fir_par_pkg::TAPS_PER_SEG;

	logic clk;
	logic rst_n;
	logic sample_valid;
	logic signed [fir_par_pkg::SAMPLE_W-1:0] sample;
	logic y_valid;
	logic signed [fir_par_pkg::Y_W-1:0] y;
	logic req_valid;
	logic req_ready;
	logic req_write;
	logic [fir_par_pkg::ADDR_W-1:0] req_addr;
	logic [fir_par_pkg::DATA_W-1:0] req_wdata;
	logic rsp_valid;
	logic rsp_ready;
	logic [fir_par_pkg::DATA_W-1:0] rsp_rdata;
	logic rsp_error;

	// handshakes as seen by the rising edge
	logic req_fire_q;
	logic rsp_fire_q;
	logic [fir_par_pkg::DATA_W-1:0] rsp_data_q;
	logic rsp_err_q;

	// reference model state
	logic signed [fir_par_pkg::SAMPLE_W-1:0] hist [NTAPS];
	logic signed [fir_par_pkg::SAMPLE_W-1:0] coef [NTAPS];
	logic signed [fir_par_pkg::SAMPLE_W-1:0] last_shift;
	logic signed [fir_par_pkg::SAMPLE_W-1:0] inj_val;
	logic signed [fir_par_pkg::Y_W-1:0] last_y;
	logic signed [fir_par_pkg::Y_W-1:0] exp_q [$];
	logic inj_armed;
	int due_q [$];
	int cyc = 0;
	logic [15:0] lfsr_q;

	tb_clk_gen u_clk_gen (
		.clk_o  (clk),
		.rst_no (rst_n)
	);

	fir_parallel uut (
		.clk_i          (clk),
		.rst_ni         (rst_n),
		.sample_valid_i (sample_valid),
		.sample_i       (sample),
		.y_valid_o      (y_valid),
		.y_o            (y),
		.req_valid_i    (req_valid),
		.req_ready_o    (req_ready),
		.req_write_i    (req_write),
		.req_addr_i     (req_addr),
		.req_wdata_i    (req_wdata),
		.rsp_valid_o    (rsp_valid),
		.rsp_ready_i    (rsp_ready),
		.rsp_rdata_o    (rsp_rdata),
		.rsp_error_o    (rsp_error)
	);

	bind fir_parallel fir_parallel_assert u_assert (
		.clk_i       (clk_i),
		.rst_ni      (rst_ni),
		.req_valid_i (req_valid_i),
		.req_ready_i (req_ready_o),
		.req_write_i (req_write_i),
		.req_addr_i  (req_addr_i),
		.req_wdata_i (req_wdata_i),
		.rsp_valid_i (rsp_valid_o),
		.rsp_ready_i (rsp_ready_i),
		.rsp_rdata_i (rsp_rdata_o),
		.rsp_error_i (rsp_error_o),
		.y_valid_i   (y_valid_o)
	);

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1, "run stopped at the first error");
	endtask

	// galois lfsr stepped once per bit
	function automatic logic [31:0] rand_bits(input int unsigned n);
		logic [31:0] r;
		logic b;
		r = '0;
		for (int i = 0; i < n; i++) begin
			b = lfsr_q[0];
			lfsr_q = lfsr_q >> 1;
			if (b) begin
				lfsr_q = lfsr_q ^ 16'hB400;
			end
			r = {r[30:0], b};
		end
		return r;
	endfunction

	function automatic logic [fir_par_pkg::ADDR_W-1:0] coef_addr(input int k);
		int a;
		a = ((k / fir_par_pkg::TAPS_PER_SEG) << fir_par_pkg::OFS_W)
			+ (k % fir_par_pkg::TAPS_PER_SEG);
		return a[fir_par_pkg::ADDR_W-1:0];
	endfunction

	function automatic logic [fir_par_pkg::ADDR_W-1:0] ctrl_addr(input int ofs);
		int a;
		a = (fir_par_pkg::REGION_CTRL << fir_par_pkg::OFS_W) + ofs;
		return a[fir_par_pkg::ADDR_W-1:0];
	endfunction

	function automatic logic [31:0] sext16(input logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	// full convolution over the eight newest samples
	task automatic model_push(input logic signed [fir_par_pkg::SAMPLE_W-1:0] x);
		logic signed [63:0] acc;
		last_shift = hist[NTAPS-1];
		for (int j = NTAPS - 1; j > 0; j--) begin
			hist[j] = hist[j-1];
		end
		hist[0] = x;
		acc = '0;
		for (int j = 0; j < NTAPS; j++) begin
			acc = acc + hist[j] * coef[j];
		end
		last_y = acc[fir_par_pkg::Y_W-1:0];
		exp_q.push_back(last_y);
		due_q.push_back(cyc + 4);
	endtask

	always @(posedge clk) begin
		req_fire_q <= req_valid & req_ready;
		rsp_fire_q <= rsp_valid & rsp_ready;
		rsp_data_q <= rsp_rdata;
		rsp_err_q <= rsp_error;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT_CYC) begin
			report_failure($sformatf("timeout, run still going after %0d cycles", cyc));
		end
	end

	// every output checked against the model and its due cycle
	always @(negedge clk) begin
		if (rst_n) begin
			if (y_valid) begin
				assert (exp_q.size() != 0)
					else report_failure("y_valid_o pulsed with no sample in flight");
				assert (cyc == due_q[0])
					else report_failure($sformatf("y_valid_o came at cycle %0d, expected at %0d",
						cyc, due_q[0]));
				assert (y === exp_q[0])
					else report_failure($sformatf("FAILED y_o: got %h, expected %h", y, exp_q[0]));
				void'(exp_q.pop_front());
				void'(due_q.pop_front());
			end else if (due_q.size() != 0) begin
				assert (cyc < due_q[0])
					else report_failure("y_valid_o missing 3 cycles after a sampling edge");
			end
		end
	end

	task automatic bus_xfer(input logic wr, input logic [fir_par_pkg::ADDR_W-1:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(negedge clk);
		req_valid = 1'b1;
		req_write = wr;
		req_addr = addr;
		req_wdata = wdata;
		rsp_ready = 1'b1;
		@(negedge clk);
		while (!req_fire_q) @(negedge clk);
		req_valid = 1'b0;
		while (!rsp_fire_q) @(negedge clk);
		rdata = rsp_data_q;
		err = rsp_err_q;
	endtask

	task automatic bus_write(input logic [fir_par_pkg::ADDR_W-1:0] addr, input logic [31:0] wdata);
		logic [31:0] rdata;
		logic err;
		int region;
		int ofs;
		bus_xfer(1'b1, addr, wdata, rdata, err);
		assert (!err) else report_failure($sformatf("write to address %h returned an error", addr));
		region = addr >> fir_par_pkg::OFS_W;
		ofs = addr % (1 << fir_par_pkg::OFS_W);
		if (region < fir_par_pkg::NUM_SEG && ofs < fir_par_pkg::TAPS_PER_SEG) begin
			coef[region * fir_par_pkg::TAPS_PER_SEG + ofs] = wdata[15:0];
		end else if (region == fir_par_pkg::REGION_CTRL && ofs == fir_par_pkg::OFS_INJECT) begin
			inj_val = wdata[15:0];
			inj_armed = 1'b1;
		end
	endtask

	task automatic bus_read_check(input logic [fir_par_pkg::ADDR_W-1:0] addr,
		input logic [31:0] expected, input string name);
		logic [31:0] rdata;
		logic err;
		bus_xfer(1'b0, addr, '0, rdata, err);
		assert (!err) else report_failure($sformatf("read of %s returned an error", name));
		assert (rdata === expected)
			else report_failure($sformatf("FAILED rsp_rdata_o (%s): got %h, expected %h",
				name, rdata, expected));
	endtask

	// one sample with the strobe held for hold cycles
	task automatic send_sample(input logic signed [15:0] v, input int unsigned hold);
		@(negedge clk);
		sample = v;
		sample_valid = 1'b1;
		model_push(inj_armed ? inj_val : v);
		inj_armed = 1'b0;
		repeat (hold) @(negedge clk);
		sample_valid = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) @(negedge clk);
		@(negedge clk);
	endtask

	task automatic test_reset_state();
		repeat (8) begin
			@(negedge clk);
			assert (!y_valid) else report_failure("y_valid_o high right after reset");
		end
		for (int k = 0; k < NTAPS; k++) begin
			bus_read_check(coef_addr(k), 32'h0, $sformatf("coef %0d", k));
		end
		bus_read_check(ctrl_addr(fir_par_pkg::OFS_Y_LO), 32'h0, "Y_LO");
		bus_read_check(ctrl_addr(fir_par_pkg::OFS_Y_HI), 32'h0, "Y_HI");
		bus_read_check(ctrl_addr(fir_par_pkg::OFS_SHIFT_OUT), 32'h0, "SHIFT_OUT");
	endtask

	task automatic test_coef_access();
		logic [31:0] pat;
		for (int k = 0; k < NTAPS; k++) begin
			// junk in the upper half and mixed signs below
			pat = 32'hDEAD_0000 | ((k * 32'h2345 + 32'h8011) & 32'hFFFF);
			bus_write(coef_addr(k), pat);
		end
		for (int k = 0; k < NTAPS; k++) begin
			bus_read_check(coef_addr(k), sext16(coef[k]), $sformatf("coef %0d", k));
		end
		bus_write(ctrl_addr(fir_par_pkg::OFS_Y_LO), 32'h1234_5678);
		bus_read_check(ctrl_addr(fir_par_pkg::OFS_Y_LO), 32'h0, "Y_LO after write");
		bus_read_check(coef_addr(0) + 5, 32'h0, "unmapped segment offset");
	endtask

	task automatic test_impulse();
		send_sample(16'sd1, 1);
		for (int n = 1; n < NTAPS; n++) begin
			// one held strobe still counts once
			send_sample(16'sd0, (n == 3) ? 5 : 1);
		end
		wait_drain();
	endtask

	task automatic test_random_stream();
		logic [31:0] r;
		for (int k = 0; k < NTAPS; k++) begin
			r = rand_bits(16);
			bus_write(coef_addr(k), r);
		end
		for (int i = 0; i < 40; i++) begin
			r = rand_bits(16);
			send_sample(r[15:0], 1);
			r = rand_bits(2);
			repeat (r % 3) @(negedge clk);
		end
		wait_drain();
	endtask

	task automatic test_injection();
		logic signed [63:0] y_ext;
		bus_write(ctrl_addr(fir_par_pkg::OFS_INJECT), 32'h5555_9C40);
		send_sample(16'sh1111, 1);
		send_sample(16'sh2222, 1);
		wait_drain();
		y_ext = last_y;
		bus_read_check(ctrl_addr(fir_par_pkg::OFS_Y_LO), y_ext[31:0], "Y_LO");
		bus_read_check(ctrl_addr(fir_par_pkg::OFS_Y_HI), y_ext[63:32], "Y_HI");
		bus_read_check(ctrl_addr(fir_par_pkg::OFS_SHIFT_OUT), sext16(last_shift), "SHIFT_OUT");
	endtask

	task automatic test_bus_errors();
		logic [31:0] rdata;
		logic err;
		logic [31:0] held;
		bus_xfer(1'b0, 6'h30, '0, rdata, err);
		assert (err === 1'b1) else report_failure("read of region 3 gave no error response");
		assert (rdata === 32'h0)
			else report_failure($sformatf("FAILED rsp_rdata_o: got %h, expected %h", rdata, 0));
		// stall the response of a coefficient read
		@(negedge clk);
		rsp_ready = 1'b0;
		req_valid = 1'b1;
		req_write = 1'b0;
		req_addr = coef_addr(2);
		@(negedge clk);
		while (!req_fire_q) @(negedge clk);
		assert (rsp_valid) else report_failure("no response one cycle after the request");
		held = rsp_rdata;
		// a second request queues behind it
		req_addr = coef_addr(5);
		repeat (6) begin
			@(negedge clk);
			assert (rsp_valid) else report_failure("rsp_valid_o dropped while stalled");
			assert (rsp_rdata === held)
				else report_failure($sformatf("FAILED rsp_rdata_o: got %h, expected %h",
					rsp_rdata, held));
			assert (!req_ready && !req_fire_q)
				else report_failure("request accepted while a response was pending");
		end
		assert (held === sext16(coef[2]))
			else report_failure($sformatf("FAILED rsp_rdata_o: got %h, expected %h",
				held, sext16(coef[2])));
		rsp_ready = 1'b1;
		while (!rsp_fire_q) @(negedge clk);
		while (!req_fire_q) @(negedge clk);
		req_valid = 1'b0;
		@(negedge clk);
		while (!rsp_fire_q) @(negedge clk);
		assert (rsp_data_q === sext16(coef[5]))
			else report_failure($sformatf("FAILED rsp_rdata_o: got %h, expected %h",
				rsp_data_q, sext16(coef[5])));
	endtask

	initial begin
		sample_valid = 1'b0;
		sample = '0;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		rsp_ready = 1'b1;
		for (int j = 0; j < NTAPS; j++) begin
			hist[j] = '0;
			coef[j] = '0;
		end
		last_shift = '0;
		last_y = '0;
		inj_val = '0;
		inj_armed = 1'b0;
		lfsr_q = 16'd22613;
		@(posedge rst_n);
		test_reset_state();
		test_coef_access();
		test_impulse();
		test_random_stream();
		test_injection();
		test_bus_errors();
		$display("test passed");
		$finish;
	end

endmodule

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_o,
	output logic rst_no
);

	// 8 ns period
	always #4 clk_o = ~clk_o;

	// reset held for 16 cycles, released on a falling edge
	initial begin
		clk_o = 1'b0;
		rst_no = 1'b0;
		repeat (16) @(posedge clk_o);
		@(negedge clk_o);
		rst_no = 1'b1;
	end

endmodule
